// ==== Makefile ====
# Verilator build and run of the FP CSR unit testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator, run the testbench, check sim.log"
	@echo "  make clean  remove obj_dir and sim.log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f verilog.f --top-module fp_csr_unit_tb -o sim_fp_csr_unit
	-./obj_dir/sim_fp_csr_unit > sim.log 2>&1
	@cat sim.log
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== source/csr_write_decode.sv ====
// FP CSR write decode
// turns a CSR instruction into per-field bit masks and data,
// plus the read selection for the addressed register

`include "fcsr_config.svh"

module csr_write_decode (
  input  fcsr_pkg::csr_req_t    csr_req_i,
  output fcsr_pkg::fcsr_write_t wr_o
);

  import fcsr_pkg::*;

  localparam int unsigned FCSR_W = `FCSR_FRM_W + `FCSR_FFLAGS_W;

  fcsr_u imm_src;
  fcsr_u mask_u;
  fcsr_u data_u;

  // zero-extended immediate for the I-forms
  assign imm_src.raw = {{(FCSR_W-5){1'b0}}, csr_req_i.rs1};

  // raw mask and data over the whole fcsr byte
  always_comb begin
    mask_u.raw = '0;
    data_u.raw = '0;
    if (csr_req_i.v) begin
      case (csr_req_i.funct3)
        `CSR_FUN3_RW: begin
          mask_u.raw = '1;
          data_u.raw = csr_req_i.wdata.raw;
        end
        `CSR_FUN3_RS: begin
          mask_u.raw = csr_req_i.wdata.raw;
          data_u.raw = csr_req_i.wdata.raw;
        end
        `CSR_FUN3_RC: begin
          mask_u.raw = csr_req_i.wdata.raw;
          data_u.raw = ~csr_req_i.wdata.raw;
        end
        `CSR_FUN3_RWI: begin
          mask_u.raw = '1;
          data_u.raw = imm_src.raw;
        end
        `CSR_FUN3_RSI: begin
          mask_u.raw = imm_src.raw;
          data_u.raw = imm_src.raw;
        end
        `CSR_FUN3_RCI: begin
          mask_u.raw = imm_src.raw;
          data_u.raw = ~imm_src.raw;
        end
        default: begin
          mask_u.raw = '0;
          data_u.raw = '0;
        end
      endcase
    end
  end

  // steer slices into the fields by address
  always_comb begin
    wr_o.csr_active  = csr_req_i.v;
    wr_o.frm_mask    = '0;
    wr_o.frm_data    = '0;
    wr_o.fflags_mask = '0;
    wr_o.fflags_data = '0;
    wr_o.rsel        = rd_none;
    case (csr_req_i.addr)
      `FCSR_ADDR_FFLAGS: begin
        wr_o.fflags_mask = mask_u.raw[`FCSR_FFLAGS_W-1:0];
        wr_o.fflags_data = data_u.raw[`FCSR_FFLAGS_W-1:0];
        wr_o.rsel        = rd_fflags;
      end
      `FCSR_ADDR_FRM: begin
        // frm alone sits in the low bits of the source
        wr_o.frm_mask = mask_u.raw[`FCSR_FRM_W-1:0];
        wr_o.frm_data = data_u.raw[`FCSR_FRM_W-1:0];
        wr_o.rsel     = rd_frm;
      end
      `FCSR_ADDR_FCSR: begin
        wr_o.fflags_mask = mask_u.f.fflags;
        wr_o.fflags_data = data_u.f.fflags;
        wr_o.frm_mask    = mask_u.f.frm;
        wr_o.frm_data    = data_u.f.frm;
        wr_o.rsel        = rd_fcsr;
      end
      default: begin
        wr_o.rsel = rd_none;
      end
    endcase
  end

endmodule

// ==== source/fcsr_config.svh ====
// FP CSR unit configuration
// field widths, CSR addresses and funct3 codes shared by the FP CSR blocks

`ifndef FCSR_CONFIG_SVH
`define FCSR_CONFIG_SVH

// field widths and flag source count
`define FCSR_FFLAGS_W 5
`define FCSR_FRM_W 3
`define FCSR_NUM_SRC 3

// FP CSR addresses
`define FCSR_ADDR_FFLAGS 12'h001
`define FCSR_ADDR_FRM 12'h002
`define FCSR_ADDR_FCSR 12'h003

// RISC-V Zicsr funct3 codes
`define CSR_FUN3_RW 3'b001
`define CSR_FUN3_RS 3'b010
`define CSR_FUN3_RC 3'b011
`define CSR_FUN3_RWI 3'b101
`define CSR_FUN3_RSI 3'b110
`define CSR_FUN3_RCI 3'b111

`endif

// ==== source/fcsr_pkg.sv ====
// FP CSR types
// flag struct, rounding modes, fcsr word views and the decode bundle

`include "fcsr_config.svh"

package fcsr_pkg;

  // accrued exception flags, nv in the msb
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  // rounding modes, 5 and 6 reserved
  typedef enum logic [`FCSR_FRM_W-1:0] {
    rne = 0,
    rtz = 1,
    rdn = 2,
    rup = 3,
    rmm = 4,
    dyn = 7
  } frm_e;

  typedef struct packed {
    frm_e    frm;
    fflags_t fflags;
  } fcsr_fields_t;

  // one fcsr byte, seen as fields or as raw bits
  typedef union packed {
    fcsr_fields_t                           f;
    logic [`FCSR_FRM_W+`FCSR_FFLAGS_W-1:0] raw;
  } fcsr_u;

  typedef struct packed {
    logic        v;
    logic [2:0]  funct3;
    logic [4:0]  rs1;
    logic [11:0] addr;
    fcsr_u       wdata;
  } csr_req_t;

  typedef enum logic [1:0] {
    rd_none,
    rd_fflags,
    rd_frm,
    rd_fcsr
  } read_sel_e;

  typedef struct packed {
    logic                     csr_active;
    logic [`FCSR_FRM_W-1:0]    frm_mask;
    logic [`FCSR_FRM_W-1:0]    frm_data;
    logic [`FCSR_FFLAGS_W-1:0] fflags_mask;
    logic [`FCSR_FFLAGS_W-1:0] fflags_data;
    read_sel_e                rsel;
  } fcsr_write_t;

endpackage

// ==== source/fcsr_regs.sv ====
// FP CSR registers
// holds frm and fflags, applies masked CSR writes bit by bit,
// accrues exception flags from the FP units and muxes the read data

`include "fcsr_config.svh"

module fcsr_regs (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  fcsr_pkg::fcsr_write_t                     wr_i,
  input  logic [`FCSR_NUM_SRC-1:0]                  fflags_v_i,
  input  fcsr_pkg::fflags_t [`FCSR_NUM_SRC-1:0]     fflags_i,
  output fcsr_pkg::frm_e                            frm_o,
  output fcsr_pkg::fcsr_u                           rdata_o,
  output logic                                      rdata_v_o
);

  import fcsr_pkg::*;

  localparam int unsigned FCSR_W = `FCSR_FRM_W + `FCSR_FFLAGS_W;

  logic [`FCSR_FRM_W-1:0]    frm_r;
  logic [`FCSR_FRM_W-1:0]    frm_n;
  logic [`FCSR_FFLAGS_W-1:0] fflags_r;
  logic [`FCSR_FFLAGS_W-1:0] fflags_n;
  logic [`FCSR_FFLAGS_W-1:0] accrue;
  logic [`FCSR_FFLAGS_W-1:0] fflags_mask;
  logic [`FCSR_FFLAGS_W-1:0] fflags_data;

  // sources: [2] div/sqrt, [1] float, [0] int convert
  always_comb begin
    accrue = '0;
    for (int i = 0; i < `FCSR_NUM_SRC; i++) begin
      if (fflags_v_i[i]) begin
        accrue = accrue | fflags_i[i];
      end
    end
  end

  // flags only accrue on cycles without a CSR access
  always_comb begin
    fflags_mask = wr_i.fflags_mask;
    fflags_data = wr_i.fflags_data;
    if (!wr_i.csr_active) begin
      fflags_mask = fflags_mask | accrue;
      fflags_data = fflags_data | accrue;
    end
  end

  // each bit takes new data only where its mask is set
  assign frm_n    = (frm_r & ~wr_i.frm_mask) | (wr_i.frm_data & wr_i.frm_mask);
  assign fflags_n = (fflags_r & ~fflags_mask) | (fflags_data & fflags_mask);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      frm_r    <= '0;
      fflags_r <= '0;
    end else begin
      frm_r    <= frm_n;
      fflags_r <= fflags_n;
    end
  end

  // read data straight from the current registers
  always_comb begin
    rdata_o.raw = '0;
    rdata_v_o   = 1'b1;
    case (wr_i.rsel)
      rd_fflags: begin
        rdata_o.raw = {{(FCSR_W-`FCSR_FFLAGS_W){1'b0}}, fflags_r};
      end
      rd_frm: begin
        rdata_o.raw = {{(FCSR_W-`FCSR_FRM_W){1'b0}}, frm_r};
      end
      rd_fcsr: begin
        rdata_o.f.frm    = frm_e'(frm_r);
        rdata_o.f.fflags = fflags_r;
      end
      default: begin
        rdata_v_o = 1'b0;
      end
    endcase
  end

  assign frm_o = frm_e'(frm_r);

endmodule

// ==== source/fp_csr_unit.sv ====
// FP control and status unit
// fflags/frm CSR access, exception flag accrual and effective
// rounding mode for an RV32 core

`include "fcsr_config.svh"

module fp_csr_unit (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  fcsr_pkg::csr_req_t                    csr_req_i,
  input  logic [`FCSR_NUM_SRC-1:0]              fflags_v_i,
  input  fcsr_pkg::fflags_t [`FCSR_NUM_SRC-1:0] fflags_i,
  input  fcsr_pkg::frm_e                        instr_rm_i,
  output fcsr_pkg::fcsr_u                       csr_rdata_o,
  output logic                                  csr_rdata_v_o,
  output fcsr_pkg::frm_e                        rm_o,
  output logic                                  rm_illegal_o
);

  import fcsr_pkg::*;

  fcsr_write_t wr;
  frm_e        frm;

  csr_write_decode i_csr_write_decode (
    .csr_req_i (csr_req_i),
    .wr_o      (wr)
  );

  fcsr_regs i_fcsr_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wr_i       (wr),
    .fflags_v_i (fflags_v_i),
    .fflags_i   (fflags_i),
    .frm_o      (frm),
    .rdata_o    (csr_rdata_o),
    .rdata_v_o  (csr_rdata_v_o)
  );

  // effective mode for the instruction in flight
  rounding_mode_resolve i_rounding_mode_resolve (
    .frm_i        (frm),
    .instr_rm_i   (instr_rm_i),
    .rm_o         (rm_o),
    .rm_illegal_o (rm_illegal_o)
  );

endmodule

// ==== source/rounding_mode_resolve.sv ====
// rounding mode resolution
// substitutes frm for the dynamic mode and flags reserved encodings

module rounding_mode_resolve (
  input  fcsr_pkg::frm_e frm_i,
  input  fcsr_pkg::frm_e instr_rm_i,
  output fcsr_pkg::frm_e rm_o,
  output logic           rm_illegal_o
);

  import fcsr_pkg::*;

  logic [2:0] rm_bits;

  // dyn picks up the mode held in frm
  always_comb begin
    if (instr_rm_i == dyn) begin
      rm_o = frm_i;
    end else begin
      rm_o = instr_rm_i;
    end
  end

  assign rm_bits = rm_o;

  // 5 and 6 are reserved, and dyn left in frm is illegal too
  always_comb begin
    case (rm_bits)
      3'd5, 3'd6, 3'd7: rm_illegal_o = 1'b1;
      default:          rm_illegal_o = 1'b0;
    endcase
  end

endmodule

// ==== tests/fp_csr_unit_tb.sv ====
// FP CSR unit testbench
// table of CSR requests and flag sources, checked against a model of frm and fflags

`include "fcsr_config.svh"

module fp_csr_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fcsr_pkg::*;

  typedef struct packed {
    csr_req_t                        req;
    logic [`FCSR_NUM_SRC-1:0]        flag_v;
    fflags_t [`FCSR_NUM_SRC-1:0]     flags;
    logic [2:0]                      rm;
    logic                            rand_flags;
    logic                            exp_v;
    logic                            exp_ill;
  } stim_row_t;

  localparam logic [11:0] addr_ff = `FCSR_ADDR_FFLAGS;
  localparam logic [11:0] addr_frm = `FCSR_ADDR_FRM;
  localparam logic [11:0] addr_fcsr = `FCSR_ADDR_FCSR;
  localparam logic [11:0] addr_other = 12'h300;
  localparam int poll_limit = 200;

  logic                            clk;
  logic                            reset;
  csr_req_t                        csr_req;
  logic [`FCSR_NUM_SRC-1:0]        fflags_v;
  fflags_t [`FCSR_NUM_SRC-1:0]     fflags;
  frm_e                            instr_rm;
  fcsr_u                           csr_rdata;
  logic                            csr_rdata_v;
  frm_e                            rm;
  logic                            rm_illegal;

  stim_row_t  rows[$];
  logic [2:0] m_frm;
  logic [4:0] m_fflags;
  int         seed;

  tb_clock_gen i_tb_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  fp_csr_unit i_fp_csr_unit (
    .clk_i         (clk),
    .reset_i       (reset),
    .csr_req_i     (csr_req),
    .fflags_v_i    (fflags_v),
    .fflags_i      (fflags),
    .instr_rm_i    (instr_rm),
    .csr_rdata_o   (csr_rdata),
    .csr_rdata_v_o (csr_rdata_v),
    .rm_o          (rm),
    .rm_illegal_o  (rm_illegal)
  );

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_val(string name, logic [7:0] exp, logic [7:0] act);
    assert (act === exp) else
      abort_run($sformatf("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                          $time, name, exp, act));
  endtask

  // polls run half a ns off the clock edges
  task automatic wait_rise();
    int n = 0;
    while (clk !== 1'b0 && n < poll_limit) begin
      #1;
      n++;
    end
    while (clk !== 1'b1 && n < poll_limit) begin
      #1;
      n++;
    end
    if (n >= poll_limit) abort_run("timeout: no rising clock edge seen");
  endtask

  task automatic wait_reset_release();
    int n = 0;
    while (reset !== 1'b0 && n < poll_limit) begin
      #1;
      n++;
    end
    if (n >= poll_limit) abort_run("timeout: reset was never released");
  endtask

  task automatic add_row(logic v, logic [2:0] f3, logic [4:0] rs1, logic [11:0] addr,
                         logic [7:0] wdata, logic [2:0] fv, logic [14:0] fl,
                         logic [2:0] rm_sel, logic [2:0] flg);
    stim_row_t r;
    r.req.v = v;
    r.req.funct3 = f3;
    r.req.rs1 = rs1;
    r.req.addr = addr;
    r.req.wdata.raw = wdata;
    r.flag_v = fv;
    r.flags = fl;
    r.rm = rm_sel;
    {r.rand_flags, r.exp_v, r.exp_ill} = flg;
    rows.push_back(r);
  endtask

  // RISC-V write semantics on one field
  function automatic logic [4:0] field_op(logic [2:0] f3, logic [4:0] old, logic [4:0] s);
    case (f3)
      `CSR_FUN3_RW, `CSR_FUN3_RWI: return s;
      `CSR_FUN3_RS, `CSR_FUN3_RSI: return old | s;
      `CSR_FUN3_RC, `CSR_FUN3_RCI: return old & ~s;
      default: return old;
    endcase
  endfunction

  function automatic logic [7:0] expected_read(logic [11:0] addr);
    case (addr)
      addr_ff: return {3'b000, m_fflags};
      addr_frm: return {5'b00000, m_frm};
      addr_fcsr: return {m_frm, m_fflags};
      default: return 8'h00;
    endcase
  endfunction

  function automatic void update_model(stim_row_t r);
    logic [7:0] src;
    logic [4:0] t;
    if (r.req.v) begin
      // I-forms take rs1 zero-extended
      src = r.req.funct3[2] ? {3'b000, r.req.rs1} : r.req.wdata.raw;
      if (r.req.addr == addr_ff || r.req.addr == addr_fcsr) begin
        m_fflags = field_op(r.req.funct3, m_fflags, src[4:0]);
      end
      if (r.req.addr == addr_frm) begin
        t = field_op(r.req.funct3, {2'b00, m_frm}, {2'b00, src[2:0]});
        m_frm = t[2:0];
      end
      if (r.req.addr == addr_fcsr) begin
        t = field_op(r.req.funct3, {2'b00, m_frm}, {2'b00, src[7:5]});
        m_frm = t[2:0];
      end
    end else begin
      for (int i = 0; i < `FCSR_NUM_SRC; i++) begin
        if (r.flag_v[i]) m_fflags = m_fflags | r.flags[i];
      end
    end
  endfunction

  task automatic fill_table();
    // v, funct3, rs1, addr, wdata, src valids, src flags {2,1,0}, instr rm,
    // {random flags, expected rdata valid, expected rm illegal}
    add_row(1'b0, 3'b000, 5'h00, addr_ff, 8'h00, 3'h0, 15'h0000, 3'd0, 3'b010);
    add_row(1'b0, 3'b000, 5'h00, addr_frm, 8'h00, 3'h0, 15'h0000, 3'd1, 3'b010);
    add_row(1'b0, 3'b000, 5'h00, addr_fcsr, 8'h00, 3'h0, 15'h0000, 3'd2, 3'b010);
    add_row(1'b0, 3'b000, 5'h00, addr_other, 8'h00, 3'h0, 15'h0000, 3'd3, 3'b000);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_ff, 8'h15, 3'h0, 15'h0000, 3'd4, 3'b010);
    add_row(1'b1, `CSR_FUN3_RS, 5'h00, addr_ff, 8'h0a, 3'h0, 15'h0000, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RC, 5'h00, addr_ff, 8'h11, 3'h0, 15'h0000, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_frm, 8'hfa, 3'h0, 15'h0000, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RS, 5'h00, addr_frm, 8'h01, 3'h0, 15'h0000, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RC, 5'h00, addr_frm, 8'h02, 3'h0, 15'h0000, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_fcsr, 8'h89, 3'h0, 15'h0000, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RS, 5'h00, addr_fcsr, 8'h32, 3'h0, 15'h0000, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RC, 5'h00, addr_fcsr, 8'ha1, 3'h0, 15'h0000, 3'd4, 3'b010);
    add_row(1'b1, `CSR_FUN3_RSI, 5'h03, addr_frm, 8'h00, 3'h0, 15'h0000, 3'd7, 3'b010);
    add_row(1'b1, `CSR_FUN3_RWI, 5'h15, addr_fcsr, 8'h00, 3'h0, 15'h0000, 3'd7, 3'b010);
    add_row(1'b1, `CSR_FUN3_RCI, 5'h04, addr_ff, 8'h00, 3'h0, 15'h0000, 3'd7, 3'b010);
    add_row(1'b1, `CSR_FUN3_RSI, 5'h1e, addr_frm, 8'h00, 3'h0, 15'h0000, 3'd7, 3'b010);
    add_row(1'b1, `CSR_FUN3_RCI, 5'h07, addr_fcsr, 8'h00, 3'h0, 15'h0000, 3'd7, 3'b011);
    add_row(1'b1, `CSR_FUN3_RWI, 5'h00, addr_frm, 8'h00, 3'h0, 15'h0000, 3'd7, 3'b011);
    // accrual on idle cycles, none while a request is active
    add_row(1'b0, 3'b000, 5'h00, addr_ff, 8'h00, 3'h1, 15'h0001, 3'd1, 3'b010);
    add_row(1'b0, 3'b000, 5'h00, addr_ff, 8'h00, 3'h6, 15'h2082, 3'd0, 3'b010);
    add_row(1'b0, 3'b000, 5'h00, addr_ff, 8'h00, 3'h0, 15'h7fff, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_ff, 8'h00, 3'h7, 15'h7fff, 3'd0, 3'b010);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_other, 8'hff, 3'h7, 15'h7fff, 3'd0, 3'b000);
    add_row(1'b1, 3'b000, 5'h00, addr_ff, 8'hff, 3'h7, 15'h0000, 3'd0, 3'b110);
    add_row(1'b0, 3'b000, 5'h00, addr_ff, 8'h00, 3'h7, 15'h0000, 3'd0, 3'b110);
    add_row(1'b0, 3'b000, 5'h00, addr_fcsr, 8'h00, 3'h5, 15'h0000, 3'd0, 3'b110);
    // dynamic mode follows frm, reserved encodings are illegal
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_frm, 8'h04, 3'h0, 15'h0000, 3'd7, 3'b010);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_frm, 8'h05, 3'h0, 15'h0000, 3'd7, 3'b010);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_frm, 8'h06, 3'h0, 15'h0000, 3'd7, 3'b011);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_frm, 8'h07, 3'h0, 15'h0000, 3'd7, 3'b011);
    add_row(1'b1, `CSR_FUN3_RW, 5'h00, addr_frm, 8'h01, 3'h0, 15'h0000, 3'd7, 3'b011);
    add_row(1'b0, 3'b000, 5'h00, addr_fcsr, 8'h00, 3'h0, 15'h0000, 3'd7, 3'b010);
    add_row(1'b0, 3'b000, 5'h00, addr_frm, 8'h00, 3'h0, 15'h0000, 3'd5, 3'b011);
    add_row(1'b0, 3'b000, 5'h00, addr_frm, 8'h00, 3'h0, 15'h0000, 3'd6, 3'b011);
  endtask

  initial begin
    stim_row_t  cur;
    logic [31:0] rnd_word;
    logic [2:0]  exp_rm;
    csr_req = '0;
    fflags_v = '0;
    fflags = '0;
    instr_rm = rne;
    m_frm = 3'd0;
    m_fflags = 5'd0;
    seed = 32'hf30c_7f9b;
    fill_table();
    #0.5;
    wait_reset_release();
    foreach (rows[k]) begin
      cur = rows[k];
      if (cur.rand_flags) begin
        rnd_word = $random(seed);
        cur.flags = rnd_word[14:0];
      end
      wait_rise();
      #1.5;
      csr_req = cur.req;
      fflags_v = cur.flag_v;
      fflags = cur.flags;
      instr_rm = frm_e'(cur.rm);
      // sample well before the next edge
      #27.5;
      exp_rm = (cur.rm == 3'd7) ? m_frm : cur.rm;
      check_val("csr_rdata_o", expected_read(cur.req.addr), csr_rdata.raw);
      check_val("csr_rdata_v_o", {7'd0, cur.exp_v}, {7'd0, csr_rdata_v});
      check_val("rm_o", {5'd0, exp_rm}, {5'd0, rm});
      check_val("rm_illegal_o", {7'd0, cur.exp_ill}, {7'd0, rm_illegal});
      update_model(cur);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock and reset
// 40 ns clock, reset held high for the first 5 rising edges

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // release a little after the 5th edge
  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

endmodule

// ==== verilog.f ====
+incdir+source
source/fcsr_pkg.sv
source/csr_write_decode.sv
source/fcsr_regs.sv
source/rounding_mode_resolve.sv
source/fp_csr_unit.sv
tests/tb_clock_gen.sv
tests/fp_csr_unit_tb.sv
